// ==== common/dcache_pkg.sv ====
// Cache geometry, address union, store size enum, request and control structs.
`default_nettype none

package dcache_pkg;

    // ------------------------------
    // Geometry.
    // ------------------------------
    localparam int LINE_W     = 512;
    localparam int DATA_W     = 64;
    localparam int ADDR_W     = 32;
    localparam int WAYS       = 2;
    localparam int SETS       = 2;
    localparam int WORD_OFF_W = 4;
    localparam int BYTE_OFF_W = 2;
    localparam int INDEX_W    = 1;
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

    // Line number and block offset split.
    localparam int BLK_OFF_W  = WORD_OFF_W + BYTE_OFF_W;
    localparam int LINE_NO_W  = ADDR_W - BLK_OFF_W;

    // ------------------------------
    // Basic types.
    // ------------------------------
    typedef logic                way_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;

    // Address as cache fields.
    typedef struct packed {
        tag_t                  tag;
        logic [INDEX_W-1:0]    index;
        logic [WORD_OFF_W-1:0] word_off;
        logic [BYTE_OFF_W-1:0] byte_off;
    } addr_fields_t;

    // Address as memory line and offset.
    typedef struct packed {
        logic [LINE_NO_W-1:0]  line_no;
        logic [BLK_OFF_W-1:0]  blk_off;
    } addr_line_t;

    typedef union packed {
        addr_fields_t fields;
        addr_line_t   line;
    } dcache_addr_u;

    // Store access size.
    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2,
        SD = 2'd3
    } store_size_e;

    // ------------------------------
    // Request and control.
    // ------------------------------
    typedef struct packed {
        dcache_addr_u addr;
        data_t        wdata;
        store_size_e  size;
    } dcache_req_t;

    typedef struct packed {
        logic store_en;
        logic fill_en;
        logic valid_set;
        logic lru_touch;
        logic addr_sel_req;
    } dcache_ctrl_t;

endpackage

`default_nettype wire

// ==== dcache/dcache_store_align.sv ====
// Store size decode into line byte mask, replicated write line and misalignment flag.
`timescale 1ns/1ns
`default_nettype none

module dcache_store_align (
    input  dcache_pkg::dcache_req_t       i_req,
    output logic [dcache_pkg::LINE_W/8-1:0] o_byte_en,
    output dcache_pkg::line_t             o_wdata_line,
    output logic                          o_misaligned
);
    import dcache_pkg::*;

    logic [BLK_OFF_W-1:0] offs;
    logic [BLK_OFF_W-1:0] base;
    logic [7:0]           lane_mask;

    assign offs = {i_req.addr.fields.word_off, i_req.addr.fields.byte_off};

    // ------------------------------
    // Lane select per size.
    // ------------------------------
    always_comb begin
        case (i_req.size)
            SB: begin
                base         = offs;
                lane_mask    = 8'h01;
                o_wdata_line = {(LINE_W/8){i_req.wdata[7:0]}};
            end
            SH: begin
                base         = {offs[BLK_OFF_W-1:1], 1'b0};
                lane_mask    = 8'h03;
                o_wdata_line = {(LINE_W/16){i_req.wdata[15:0]}};
            end
            SW: begin
                base         = {offs[BLK_OFF_W-1:2], 2'b00};
                lane_mask    = 8'h0f;
                o_wdata_line = {(LINE_W/32){i_req.wdata[31:0]}};
            end
            default: begin
                base         = {offs[BLK_OFF_W-1:3], 3'b000};
                lane_mask    = 8'hff;
                o_wdata_line = {(LINE_W/DATA_W){i_req.wdata}};
            end
        endcase
    end

    assign o_byte_en = {{(LINE_W/8-8){1'b0}}, lane_mask} << base;

    // Misaligned stores are still written.
    always_comb begin
        case (i_req.size)
            SH:      o_misaligned = i_req.addr.fields.byte_off[0];
            SW:      o_misaligned = |i_req.addr.fields.byte_off;
            SD:      o_misaligned = (|i_req.addr.fields.byte_off) |
                                    i_req.addr.fields.word_off[0];
            default: o_misaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== dcache/dcache_tag_store.sv ====
// Tag and valid arrays, tag compare, way select and refill tag write.
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_store (
    input  wire                       clk,
    input  wire                       arst,
    input  dcache_pkg::dcache_addr_u  i_addr,
    input  wire                       i_fill_en,
    input  wire                       i_valid_set,
    input  dcache_pkg::way_t          i_victim,
    output logic                      o_hit,
    output dcache_pkg::way_t          o_way,
    output dcache_pkg::tag_t          o_victim_tag
);
    import dcache_pkg::*;

    tag_t                       tag_mem [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0]  valid_q;
    logic [WAYS-1:0]            way_hit;
    logic [INDEX_W-1:0]         index;

    assign index = i_addr.fields.index;

    // ------------------------------
    // Lookup.
    // ------------------------------
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_mem[index][w] == i_addr.fields.tag);
        end
    end

    assign o_hit = |way_hit;

    // Lower hitting way wins, victim on a miss.
    always_comb begin
        if (way_hit[0]) begin
            o_way = 1'b0;
        end else if (way_hit[1]) begin
            o_way = 1'b1;
        end else begin
            o_way = i_victim;
        end
    end

    assign o_victim_tag = tag_mem[index][i_victim];

    // ------------------------------
    // Refill.
    // ------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    tag_mem[s][w] <= '0;
                end
            end
        end else if (i_fill_en) begin
            tag_mem[index][i_victim] <= i_addr.fields.tag;
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= '0;
        end else if (i_valid_set) begin
            valid_q[index][i_victim] <= 1'b1;
        end
    end

    // One line per set holds a given tag.
    a_single_hit: assert property (@(posedge clk) disable iff (arst)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

// ==== dcache/dcache_lru.sv ====
// Per-set LRU state and victim way.
`timescale 1ns/1ns
`default_nettype none

module dcache_lru (
    input  wire                             clk,
    input  wire                             arst,
    input  wire [dcache_pkg::INDEX_W-1:0]   i_index,
    input  wire                             i_touch,
    input  dcache_pkg::way_t                i_way,
    output dcache_pkg::way_t                o_victim
);
    import dcache_pkg::*;

    // With two ways the order reduces to the least recent way.
    way_t victim_q [SETS];

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int s = 0; s < SETS; s++) begin
                victim_q[s] <= 1'b0;
            end
        end else if (i_touch) begin
            // Touched way becomes most recent.
            victim_q[i_index] <= ~i_way;
        end
    end

    assign o_victim = victim_q[i_index];

endmodule

`default_nettype wire

// ==== dcache/dcache_data_store.sv ====
// Line data and dirty arrays, store merge, refill, load window and victim line.
`timescale 1ns/1ns
`default_nettype none

module dcache_data_store (
    input  wire                             clk,
    input  wire                             arst,
    input  dcache_pkg::dcache_addr_u        i_addr,
    input  wire                             i_store_en,
    input  wire                             i_fill_en,
    input  dcache_pkg::way_t                i_way,
    input  dcache_pkg::way_t                i_victim,
    input  wire [dcache_pkg::LINE_W/8-1:0]  i_byte_en,
    input  dcache_pkg::line_t               i_wdata_line,
    input  dcache_pkg::line_t               i_fill_line,
    output dcache_pkg::data_t               o_rdata,
    output logic                            o_dirty,
    output dcache_pkg::line_t               o_victim_line
);
    import dcache_pkg::*;

    line_t                      data_mem [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0]  dirty_q;
    logic [INDEX_W-1:0]         index;
    line_t                      sel_line;
    line_t                      bit_mask;
    line_t                      merged_line;
    logic [LINE_W+31:0]         read_ext;

    assign index    = i_addr.fields.index;
    assign sel_line = data_mem[index][i_way];

    // ------------------------------
    // Store merge.
    // ------------------------------
    always_comb begin
        for (int b = 0; b < LINE_W/8; b++) begin
            bit_mask[b*8 +: 8] = {8{i_byte_en[b]}};
        end
    end

    assign merged_line = (sel_line & ~bit_mask) | (i_wdata_line & bit_mask);

    // Store wins over refill.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    data_mem[s][w] <= '0;
                end
            end
        end else if (i_store_en) begin
            data_mem[index][i_way] <= merged_line;
        end else if (i_fill_en) begin
            data_mem[index][i_victim] <= i_fill_line;
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            dirty_q <= '0;
        end else if (i_store_en) begin
            dirty_q[index][i_way] <= 1'b1;
        end else if (i_fill_en) begin
            dirty_q[index][i_victim] <= 1'b0;
        end
    end

    // ------------------------------
    // Read side.
    // ------------------------------
    // Zero pad so word 15 returns a zero upper half.
    assign read_ext = {32'b0, sel_line};
    assign o_rdata  = read_ext[{i_addr.fields.word_off, 5'b0} +: DATA_W];

    assign o_dirty       = dirty_q[index][i_victim];
    assign o_victim_line = data_mem[index][i_victim];

    // Controller issues one write command per cycle.
    a_one_cmd: assert property (@(posedge clk) disable iff (arst)
        !(i_store_en && i_fill_en));

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
// Data cache top level with sub-block wiring and memory address select.
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire                         clk,
    input  wire                         arst,
    input  dcache_pkg::dcache_req_t     i_req,
    input  dcache_pkg::dcache_ctrl_t    i_ctrl,
    input  dcache_pkg::line_t           i_fill_line,
    output dcache_pkg::data_t           o_rdata,
    output logic                        o_hit,
    output logic                        o_dirty,
    output dcache_pkg::line_t           o_victim_line,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_addr,
    output logic                        o_store_misaligned
);
    import dcache_pkg::*;

    logic [LINE_W/8-1:0] byte_en;
    line_t               wdata_line;
    way_t                way;
    way_t                victim;
    tag_t                victim_tag;

    dcache_store_align store_align_inst (
        .i_req        (i_req),
        .o_byte_en    (byte_en),
        .o_wdata_line (wdata_line),
        .o_misaligned (o_store_misaligned)
    );

    dcache_tag_store tag_store_inst (
        .clk          (clk),
        .arst         (arst),
        .i_addr       (i_req.addr),
        .i_fill_en    (i_ctrl.fill_en),
        .i_valid_set  (i_ctrl.valid_set),
        .i_victim     (victim),
        .o_hit        (o_hit),
        .o_way        (way),
        .o_victim_tag (victim_tag)
    );

    dcache_lru lru_inst (
        .clk      (clk),
        .arst     (arst),
        .i_index  (i_req.addr.fields.index),
        .i_touch  (i_ctrl.lru_touch),
        .i_way    (way),
        .o_victim (victim)
    );

    dcache_data_store data_store_inst (
        .clk           (clk),
        .arst          (arst),
        .i_addr        (i_req.addr),
        .i_store_en    (i_ctrl.store_en),
        .i_fill_en     (i_ctrl.fill_en),
        .i_way         (way),
        .i_victim      (victim),
        .i_byte_en     (byte_en),
        .i_wdata_line  (wdata_line),
        .i_fill_line   (i_fill_line),
        .o_rdata       (o_rdata),
        .o_dirty       (o_dirty),
        .o_victim_line (o_victim_line)
    );

    // Requested line for refill, victim line for writeback.
    assign o_mem_addr = i_ctrl.addr_sel_req ?
        {i_req.addr.line.line_no, {BLK_OFF_W{1'b0}}} :
        {victim_tag, i_req.addr.fields.index, {BLK_OFF_W{1'b0}}};

endmodule

`default_nettype wire

// ==== test/tb_dcache_checks.svh ====
// Error counters and typed compare tasks for the data cache testbench.
`ifndef TB_DCACHE_CHECKS_SVH
`define TB_DCACHE_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_data(input string name, input string field,
                          input data_t exp, input data_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
    end
endtask

task automatic check_line(input string name, input string field,
                          input line_t exp, input line_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
    end
endtask

task automatic check_addr(input string name, input string field,
                          input logic [ADDR_W-1:0] exp, input logic [ADDR_W-1:0] act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
    end
endtask

task automatic check_bit(input string name, input string field,
                         input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("[FAIL] %s %s expected %b actual %b", name, field, exp, act);
    end
endtask

`endif

// ==== test/tb_dcache_top.sv ====
// Data cache testbench with clock, reset, stimulus table, reference model and watchdog.
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_top;
    import dcache_pkg::*;

    `include "tb_dcache_checks.svh"

    localparam int MAX_ROWS = 96;

    // Bit order is store, fill, valid_set, touch and addr_sel_req.
    localparam dcache_ctrl_t C_LOAD  = 5'b00000;
    localparam dcache_ctrl_t C_REQ   = 5'b00001;
    localparam dcache_ctrl_t C_TOUCH = 5'b00010;
    localparam dcache_ctrl_t C_STORE = 5'b10000;
    localparam dcache_ctrl_t C_FILL  = 5'b01111;

    localparam tag_t TAG_A = 25'h0a5a5a;
    localparam tag_t TAG_B = 25'h13c3c3;
    localparam tag_t TAG_C = 25'h0f0f0f;
    localparam tag_t TAG_D = 25'h1e1e1e;

    typedef struct packed {
        dcache_req_t       req;
        dcache_ctrl_t      ctrl;
        line_t             fill;
        logic              exp_hit;
        data_t             exp_rdata;
        logic              exp_dirty;
        line_t             exp_victim_line;
        logic [ADDR_W-1:0] exp_mem_addr;
        logic              exp_misaligned;
    } row_t;

    logic              clk;
    logic              arst;
    dcache_req_t       req;
    dcache_ctrl_t      ctrl;
    line_t             fill_line;
    data_t             rdata;
    logic              hit;
    logic              dirty;
    line_t             victim_line;
    logic [ADDR_W-1:0] mem_addr;
    logic              misaligned;

    row_t   table_rows [MAX_ROWS];
    string  row_names  [MAX_ROWS];
    int     n_rows = 0;
    logic   table_ready = 1'b0;
    integer seed;

    // Reference model state.
    line_t  m_data   [SETS][WAYS];
    tag_t   m_tag    [SETS][WAYS];
    logic   m_valid  [SETS][WAYS];
    logic   m_dirty  [SETS][WAYS];
    way_t   m_victim [SETS];

    dcache_top dcache_top_inst (
        .clk                (clk),
        .arst               (arst),
        .i_req              (req),
        .i_ctrl             (ctrl),
        .i_fill_line        (fill_line),
        .o_rdata            (rdata),
        .o_hit              (hit),
        .o_dirty            (dirty),
        .o_victim_line      (victim_line),
        .o_mem_addr         (mem_addr),
        .o_store_misaligned (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Stimulus helpers.
    // ------------------------------
    function automatic dcache_addr_u make_addr(input tag_t tag, input logic [INDEX_W-1:0] idx,
                                               input logic [WORD_OFF_W-1:0] word,
                                               input logic [BYTE_OFF_W-1:0] byt);
        dcache_addr_u a;
        a.fields.tag      = tag;
        a.fields.index    = idx;
        a.fields.word_off = word;
        a.fields.byte_off = byt;
        return a;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < LINE_W / 32; i++) begin
            l[i * 32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // 64-bit window from a 32-bit word, zero past the line end.
    function automatic data_t window_of(input line_t l, input logic [WORD_OFF_W-1:0] word);
        data_t r;
        int    first;
        first = word * 4;
        for (int j = 0; j < DATA_W / 8; j++) begin
            if (first + j < LINE_W / 8) begin
                r[j * 8 +: 8] = l[(first + j) * 8 +: 8];
            end else begin
                r[j * 8 +: 8] = 8'h00;
            end
        end
        return r;
    endfunction

    function automatic logic expect_misaligned(input store_size_e size,
                                               input logic [WORD_OFF_W-1:0] word,
                                               input logic [BYTE_OFF_W-1:0] byt);
        case (size)
            SB:      return 1'b0;
            SH:      return byt[0];
            SW:      return byt != 2'b00;
            default: return (byt != 2'b00) || word[0];
        endcase
    endfunction

    task automatic add_row(input string name, input dcache_addr_u addr, input store_size_e size,
                           input data_t wdata, input dcache_ctrl_t c, input line_t fill);
        row_t row;
        row           = '0;
        row.req.addr  = addr;
        row.req.size  = size;
        row.req.wdata = wdata;
        row.ctrl      = c;
        row.fill      = fill;
        table_rows[n_rows] = row;
        row_names[n_rows]  = name;
        n_rows++;
    endtask

    // ------------------------------
    // Stimulus table.
    // ------------------------------
    task automatic build_table();
        data_t wd;
        line_t fl;
        add_row("reset_miss_a", make_addr(TAG_A, 1'b0, 4'd0, 2'd0), SB, '0, C_LOAD, '0);
        add_row("reset_miss_b", make_addr(TAG_B, 1'b1, 4'd5, 2'd0), SB, '0, C_LOAD, '0);
        add_row("reset_miss_zero", make_addr('0, 1'b0, 4'd0, 2'd0), SB, '0, C_REQ, '0);

        // Refill, then a window at every word.
        fl = random_line();
        add_row("fill_a", make_addr(TAG_A, 1'b0, 4'd0, 2'd0), SB, '0, C_FILL, fl);
        for (int w = 0; w < 16; w++) begin
            add_row($sformatf("load_a_w%0d", w), make_addr(TAG_A, 1'b0, 4'(w), 2'd0),
                    SB, '0, C_LOAD, '0);
        end

        // Aligned stores of each size.
        wd = {$random(seed), $random(seed)};
        add_row("sb_a", make_addr(TAG_A, 1'b0, 4'd3, 2'd1), SB, wd, C_STORE, '0);
        wd = {$random(seed), $random(seed)};
        add_row("sh_a", make_addr(TAG_A, 1'b0, 4'd4, 2'd2), SH, wd, C_STORE, '0);
        wd = {$random(seed), $random(seed)};
        add_row("sw_a", make_addr(TAG_A, 1'b0, 4'd5, 2'd0), SW, wd, C_STORE, '0);
        wd = {$random(seed), $random(seed)};
        add_row("sd_a", make_addr(TAG_A, 1'b0, 4'd6, 2'd0), SD, wd, C_STORE, '0);
        for (int w = 2; w < 8; w++) begin
            add_row($sformatf("merged_w%0d", w), make_addr(TAG_A, 1'b0, 4'(w), 2'd0),
                    SB, '0, C_LOAD, '0);
        end

        // Misalignment flag only.
        for (int s = 0; s < 4; s++) begin
            for (int w = 2; w < 4; w++) begin
                for (int b = 0; b < 4; b++) begin
                    add_row($sformatf("misalign_s%0d_w%0d_b%0d", s, w, b),
                            make_addr(TAG_A, 1'b0, 4'(w), 2'(b)), store_size_e'(s),
                            '0, C_LOAD, '0);
                end
            end
        end

        // Eviction in set 0.
        fl = random_line();
        add_row("fill_c_way1", make_addr(TAG_C, 1'b0, 4'd0, 2'd0), SB, '0, C_FILL, fl);
        add_row("victim_dirty_a", make_addr(TAG_D, 1'b0, 4'd0, 2'd0), SB, '0, C_LOAD, '0);
        add_row("touch_a", make_addr(TAG_A, 1'b0, 4'd1, 2'd0), SB, '0, C_TOUCH, '0);
        add_row("miss_d_wb", make_addr(TAG_D, 1'b0, 4'd2, 2'd0), SB, '0, C_LOAD, '0);
        add_row("miss_d_req", make_addr(TAG_D, 1'b0, 4'd2, 2'd0), SB, '0, C_REQ, '0);
        fl = random_line();
        add_row("fill_d", make_addr(TAG_D, 1'b0, 4'd0, 2'd0), SB, '0, C_FILL, fl);
        add_row("hit_d", make_addr(TAG_D, 1'b0, 4'd9, 2'd0), SB, '0, C_LOAD, '0);
        add_row("miss_c_evicts_a", make_addr(TAG_C, 1'b0, 4'd0, 2'd0), SB, '0, C_LOAD, '0);

        // Set 1 and the last word.
        fl = random_line();
        add_row("fill_b", make_addr(TAG_B, 1'b1, 4'd0, 2'd0), SB, '0, C_FILL, fl);
        add_row("hit_b_w15", make_addr(TAG_B, 1'b1, 4'd15, 2'd0), SB, '0, C_LOAD, '0);
        wd = {$random(seed), $random(seed)};
        add_row("sd_b_w14", make_addr(TAG_B, 1'b1, 4'd14, 2'd0), SD, wd, C_STORE, '0);
        add_row("load_b_w14", make_addr(TAG_B, 1'b1, 4'd14, 2'd0), SB, '0, C_LOAD, '0);
        add_row("set0_kept", make_addr(TAG_A, 1'b0, 4'd6, 2'd0), SB, '0, C_LOAD, '0);
    endtask

    // ------------------------------
    // Reference model.
    // ------------------------------
    task automatic run_model();
        dcache_addr_u       a;
        dcache_ctrl_t       c;
        logic [INDEX_W-1:0] idx;
        way_t               victim;
        way_t               way;
        logic               hit_m;
        int                 base;
        int                 nbytes;
        for (int s = 0; s < SETS; s++) begin
            m_victim[s] = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                m_data[s][w]  = '0;
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        for (int r = 0; r < n_rows; r++) begin
            a      = table_rows[r].req.addr;
            c      = table_rows[r].ctrl;
            idx    = a.fields.index;
            victim = m_victim[idx];
            hit_m  = 1'b0;
            way    = victim;
            // Walk down so the lower hitting way is kept.
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (m_valid[idx][w] && m_tag[idx][w] == a.fields.tag) begin
                    hit_m = 1'b1;
                    way   = way_t'(w);
                end
            end
            table_rows[r].exp_hit         = hit_m;
            table_rows[r].exp_rdata       = window_of(m_data[idx][way], a.fields.word_off);
            table_rows[r].exp_dirty       = m_dirty[idx][victim];
            table_rows[r].exp_victim_line = m_data[idx][victim];
            table_rows[r].exp_misaligned  = expect_misaligned(table_rows[r].req.size,
                                                              a.fields.word_off,
                                                              a.fields.byte_off);
            if (c.addr_sel_req) begin
                table_rows[r].exp_mem_addr = {a.fields.tag, idx, 6'b000000};
            end else begin
                table_rows[r].exp_mem_addr = {m_tag[idx][victim], idx, 6'b000000};
            end

            // State after the edge.
            if (c.store_en) begin
                case (table_rows[r].req.size)
                    SB:      nbytes = 1;
                    SH:      nbytes = 2;
                    SW:      nbytes = 4;
                    default: nbytes = 8;
                endcase
                base = a.fields.word_off * 4 + a.fields.byte_off;
                for (int j = 0; j < nbytes; j++) begin
                    m_data[idx][way][(base + j) * 8 +: 8] = table_rows[r].req.wdata[j * 8 +: 8];
                end
                m_dirty[idx][way] = 1'b1;
            end else if (c.fill_en) begin
                m_data[idx][victim]  = table_rows[r].fill;
                m_dirty[idx][victim] = 1'b0;
            end
            if (c.fill_en) begin
                m_tag[idx][victim] = a.fields.tag;
            end
            if (c.valid_set) begin
                m_valid[idx][victim] = 1'b1;
            end
            if (c.lru_touch) begin
                m_victim[idx] = ~way;
            end
        end
    endtask

    task automatic apply_rows();
        for (int r = 0; r < n_rows; r++) begin
            @(posedge clk);
            req       <= table_rows[r].req;
            ctrl      <= table_rows[r].ctrl;
            fill_line <= table_rows[r].fill;
            @(negedge clk);
            check_bit(row_names[r], "hit", table_rows[r].exp_hit, hit);
            check_data(row_names[r], "rdata", table_rows[r].exp_rdata, rdata);
            check_bit(row_names[r], "dirty", table_rows[r].exp_dirty, dirty);
            check_line(row_names[r], "victim_line", table_rows[r].exp_victim_line, victim_line);
            check_addr(row_names[r], "mem_addr", table_rows[r].exp_mem_addr, mem_addr);
            check_bit(row_names[r], "misaligned", table_rows[r].exp_misaligned, misaligned);
        end
        @(posedge clk);
        ctrl <= '0;
    endtask

    initial begin
        seed      = 32'hd8a65d2b;
        arst      = 1'b1;
        req       = '0;
        ctrl      = '0;
        fill_line = '0;
        build_table();
        run_model();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        arst <= 1'b0;
        apply_rows();
        $display("Summary: %0d rows, %0d checks, %0d errors", n_rows, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((n_rows + 32) * 10);
        $display("Timeout: the stimulus loop did not finish within %0d cycles", n_rows + 32);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
common/dcache_pkg.sv
dcache/dcache_store_align.sv
dcache/dcache_tag_store.sv
dcache/dcache_lru.sv
dcache/dcache_data_store.sv
hw/dcache_top.sv
test/tb_dcache_top.sv

// ==== Makefile ====
TOP := tb_dcache_top
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ns -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@./obj_dir/sim_$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f project.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
